// File: src/rename_pkg.sv
package rename_pkg;

    localparam int NUM_LOGICAL = 32;
    localparam int PREG_W      = 6;
    localparam int LREG_W      = 5;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [LREG_W-1:0] lreg_t;

    // whole logical-to-physical mapping, entry i is for xi
    typedef preg_t [NUM_LOGICAL-1:0] map_table_t;

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0] funct7;
        lreg_t      rs2;
        lreg_t      rs1;
        logic [2:0] funct3;
        lreg_t      rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        lreg_t       rs1;
        logic [2:0]  funct3;
        lreg_t       rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // one instruction word, two views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        preg_t ps1;
        preg_t ps2;
        preg_t pd;         // zero when nothing is written
        preg_t old_pd;     // freed at commit
        logic  uses_rs2;
        logic  writes_rd;
    } rename_out_t;

endpackage

// File: src/rename_map_table.sv
`timescale 1ns/1ps

module rename_map_table (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    map_we,
    input  rename_pkg::lreg_t       map_rd,
    input  rename_pkg::preg_t       map_pd,
    input  logic                    exception_sig,
    input  logic                    mret_sig,
    output rename_pkg::map_table_t  map_state,
    output logic                    restore_done
);

    rename_pkg::map_table_t cur_map;
    rename_pkg::map_table_t bak_map;
    rename_pkg::map_table_t cur_next;
    rename_pkg::map_table_t bak_next;
    rename_pkg::map_table_t init_map;
    logic                   mret_q;

    // identity mapping, xi -> pi
    always_comb begin
        for (int i = 0; i < rename_pkg::NUM_LOGICAL; i++) begin
            init_map[i] = rename_pkg::preg_t'(i);
        end
    end

    // exception beats mret, mret beats a write
    always_comb begin
        cur_next = cur_map;
        bak_next = bak_map;
        if (exception_sig) begin
            bak_next = cur_map;                       // snapshot at trap entry
        end else if (mret_sig) begin
            cur_next = bak_map;                       // roll back to trap entry
        end else if (map_we && map_rd != '0) begin
            cur_next[map_rd] = map_pd;                // x0 stays p0
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_map <= init_map;
            bak_map <= init_map;
        end else begin
            cur_map <= cur_next;
            bak_map <= bak_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mret_q <= 1'b0;
        end else begin
            mret_q <= mret_sig;                       // restore visible next cycle
        end
    end

    assign map_state    = cur_map;
    assign restore_done = mret_q;

endmodule

// File: src/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int PREG_W = rename_pkg::PREG_W
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc,
    input  logic              commit_valid,
    input  logic [PREG_W-1:0] commit_preg,
    input  logic              exception_sig,
    input  logic              mret_sig,
    output logic [PREG_W-1:0] free_head,
    output logic              free_empty
);

    localparam int DEPTH = (1 << PREG_W) - rename_pkg::NUM_LOGICAL;
    localparam int IDX_W = $clog2(DEPTH);

    // wrap bit tells full from empty
    typedef struct packed {
        logic             wrap;
        logic [IDX_W-1:0] idx;
    } ptr_t;

    logic [PREG_W-1:0] fifo_mem [DEPTH];
    ptr_t              rd_ptr;
    ptr_t              wr_ptr;
    ptr_t              saved_rd_ptr;
    logic              free_full;
    logic              push;
    logic              pop;

    // depth need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_t n;
        n = p;
        if (p.idx == IDX_W'(DEPTH - 1)) begin
            n.idx  = '0;
            n.wrap = ~p.wrap;
        end else begin
            n.idx = p.idx + 1'b1;
        end
        return n;
    endfunction

    assign free_empty = (rd_ptr == wr_ptr);
    assign free_full  = (rd_ptr.wrap != wr_ptr.wrap) && (rd_ptr.idx == wr_ptr.idx);
    assign push       = commit_valid && !free_full;
    assign pop        = alloc && !free_empty;
    assign free_head  = fifo_mem[rd_ptr.idx];

    // starts full with the registers above the logical ones
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                fifo_mem[i] <= PREG_W'(rename_pkg::NUM_LOGICAL + i);
            end
        end else if (push) begin
            fifo_mem[wr_ptr.idx] <= commit_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '{wrap: 1'b1, idx: '0};
        end else if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);                // commits land in any cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr       <= '0;
            saved_rd_ptr <= '0;
        end else if (exception_sig) begin
            saved_rd_ptr <= rd_ptr;
        end else if (mret_sig) begin
            rd_ptr <= saved_rd_ptr;                   // trap allocations go back to the pool
        end else if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
    end

endmodule

// File: src/rename_stage.sv
`timescale 1ns/1ps

module rename_stage #(
    parameter int PREG_W = rename_pkg::PREG_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  rename_pkg::instr_u      instr,
    input  logic                    exception_sig,
    input  logic                    mret_sig,
    input  rename_pkg::map_table_t  map_state,
    input  logic [PREG_W-1:0]       free_head,
    input  logic                    free_empty,
    output logic                    stall,
    output logic                    alloc,
    output logic                    map_we,
    output rename_pkg::lreg_t       map_rd,
    output logic [PREG_W-1:0]       map_pd,
    output logic                    out_valid,
    output rename_pkg::rename_out_t out
);

    typedef struct packed {
        rename_pkg::lreg_t rs1;
        rename_pkg::lreg_t rs2;
        rename_pkg::lreg_t rd;
        logic              uses_rs2;
        logic              writes_rd;
    } decode_t;

    decode_t                 dec;
    rename_pkg::rename_out_t res_next;
    logic                    is_reg;
    logic                    is_imm;
    logic                    event_sig;
    logic                    accept;

    // opcode sits at the same bits in both views
    assign is_reg = (instr.r.opcode == rename_pkg::OP_REG);
    assign is_imm = (instr.i.opcode == rename_pkg::OP_IMM);

    always_comb begin
        dec     = '0;
        dec.rs1 = instr.i.rs1;                        // same bits in both views
        dec.rd  = instr.i.rd;
        if (is_reg) begin
            dec.rs2      = instr.r.rs2;
            dec.uses_rs2 = 1'b1;
        end
        dec.writes_rd = (is_reg || is_imm) && (dec.rd != '0);
    end

    assign event_sig = exception_sig || mret_sig;
    assign stall     = event_sig || (instr_valid && dec.writes_rd && free_empty);
    assign accept    = instr_valid && !stall;

    assign alloc  = accept && dec.writes_rd;
    assign map_we = alloc;
    assign map_rd = dec.rd;
    assign map_pd = free_head;

    // lookups use the map before this instruction's write
    always_comb begin
        res_next           = '0;
        res_next.ps1       = map_state[dec.rs1];
        res_next.uses_rs2  = dec.uses_rs2;
        res_next.writes_rd = dec.writes_rd;
        if (dec.uses_rs2) begin
            res_next.ps2 = map_state[dec.rs2];
        end
        if (dec.writes_rd) begin
            res_next.pd     = free_head;
            res_next.old_pd = map_state[dec.rd];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;                      // one-cycle pulse per instruction
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out <= res_next;
        end
    end

endmodule

// File: src/rename_top.sv
`timescale 1ns/1ps

module rename_top #(
    parameter int PREG_W = rename_pkg::PREG_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  rename_pkg::instr_u      instr,
    input  logic                    commit_valid,
    input  rename_pkg::preg_t       commit_preg,
    input  logic                    exception_sig,
    input  logic                    mret_sig,
    output logic                    stall,
    output logic                    out_valid,
    output rename_pkg::rename_out_t out,
    output logic                    restore_done
);

    rename_pkg::map_table_t map_state;
    logic                   map_we;
    rename_pkg::lreg_t      map_rd;
    logic [PREG_W-1:0]      map_pd;
    logic [PREG_W-1:0]      free_head;
    logic                   free_empty;
    logic                   alloc;

    rename_stage #(
        .PREG_W (PREG_W)
    ) i_rename_stage (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .exception_sig (exception_sig),
        .mret_sig      (mret_sig),
        .map_state     (map_state),
        .free_head     (free_head),
        .free_empty    (free_empty),
        .stall         (stall),
        .alloc         (alloc),
        .map_we        (map_we),
        .map_rd        (map_rd),
        .map_pd        (map_pd),
        .out_valid     (out_valid),
        .out           (out)
    );

    rename_map_table i_rename_map_table (
        .clk           (clk),
        .reset         (reset),
        .map_we        (map_we),
        .map_rd        (map_rd),
        .map_pd        (map_pd),
        .exception_sig (exception_sig),
        .mret_sig      (mret_sig),
        .map_state     (map_state),
        .restore_done  (restore_done)
    );

    free_list #(
        .PREG_W (PREG_W)
    ) i_free_list (
        .clk           (clk),
        .reset         (reset),
        .alloc         (alloc),
        .commit_valid  (commit_valid),
        .commit_preg   (commit_preg),
        .exception_sig (exception_sig),
        .mret_sig      (mret_sig),
        .free_head     (free_head),
        .free_empty    (free_empty)
    );

endmodule

// File: sim/rename_sva.sv
`timescale 1ns/1ps

module rename_sva (
    input logic clk,
    input logic reset,
    input logic exception_sig,
    input logic mret_sig,
    input logic stall,
    input logic out_valid,
    input logic restore_done
);

    no_valid_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

    // trap events block renaming
    stall_on_event: assert property (
        @(posedge clk) disable iff (reset) (exception_sig || mret_sig) |-> stall
    ) else $error("stall low while a trap event is present");

    restore_after_mret: assert property (
        @(posedge clk) disable iff (reset) mret_sig |=> restore_done
    ) else $error("restore_done missing one cycle after mret");

    restore_only_after_mret: assert property (
        @(posedge clk) disable iff (reset) restore_done |-> $past(mret_sig)
    ) else $error("restore_done without mret in the previous cycle");

endmodule

// File: sim/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

    localparam time CLK_PERIOD = 40ns;
    localparam int  MAX_WAIT   = 10;

    localparam int KIND_RENAME = 0;
    localparam int KIND_COMMIT = 1;
    localparam int KIND_EXC    = 2;
    localparam int KIND_MRET   = 3;

    typedef struct {
        string                   name;
        int                      kind;
        rename_pkg::instr_u      word;
        rename_pkg::preg_t       preg;
        logic                    exp_stall;
        rename_pkg::rename_out_t exp;
    } step_t;

    logic                    clk;
    logic                    reset;
    logic                    instr_valid;
    rename_pkg::instr_u      instr;
    logic                    commit_valid;
    rename_pkg::preg_t       commit_preg;
    logic                    exception_sig;
    logic                    mret_sig;
    logic                    stall;
    logic                    out_valid;
    rename_pkg::rename_out_t out;
    logic                    restore_done;

    step_t steps[$];
    int    seed;
    int    errors;
    int    checks;

    rename_top i_rename_top (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .commit_valid  (commit_valid),
        .commit_preg   (commit_preg),
        .exception_sig (exception_sig),
        .mret_sig      (mret_sig),
        .stall         (stall),
        .out_valid     (out_valid),
        .out           (out),
        .restore_done  (restore_done)
    );

    bind rename_top rename_sva i_rename_sva (
        .clk           (clk),
        .reset         (reset),
        .exception_sig (exception_sig),
        .mret_sig      (mret_sig),
        .stall         (stall),
        .out_valid     (out_valid),
        .restore_done  (restore_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // funct fields are noise for the rename logic
    function automatic rename_pkg::instr_u r_type_word(input rename_pkg::lreg_t rd,
                                                      input rename_pkg::lreg_t rs1,
                                                      input rename_pkg::lreg_t rs2);
        rename_pkg::instr_u w;
        w.r.funct7 = 7'($random(seed));
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = 3'($random(seed));
        w.r.rd     = rd;
        w.r.opcode = rename_pkg::OP_REG;
        return w;
    endfunction

    function automatic rename_pkg::instr_u i_type_word(input rename_pkg::lreg_t rd,
                                                      input rename_pkg::lreg_t rs1);
        rename_pkg::instr_u w;
        w.i.imm12  = 12'($random(seed));              // lands where rs2 sits in R-type
        w.i.rs1    = rs1;
        w.i.funct3 = 3'($random(seed));
        w.i.rd     = rd;
        w.i.opcode = rename_pkg::OP_IMM;
        return w;
    endfunction

    function automatic rename_pkg::rename_out_t make_result(input rename_pkg::preg_t ps1,
                                                           input rename_pkg::preg_t ps2,
                                                           input rename_pkg::preg_t pd,
                                                           input rename_pkg::preg_t old_pd,
                                                           input logic uses_rs2,
                                                           input logic writes_rd);
        rename_pkg::rename_out_t r;
        r.ps1       = ps1;
        r.ps2       = ps2;
        r.pd        = pd;
        r.old_pd    = old_pd;
        r.uses_rs2  = uses_rs2;
        r.writes_rd = writes_rd;
        return r;
    endfunction

    task automatic add_rename(input string name, input rename_pkg::instr_u word,
                              input logic exp_stall, input rename_pkg::rename_out_t exp);
        step_t s;
        s.name      = name;
        s.kind      = KIND_RENAME;
        s.word      = word;
        s.preg      = '0;
        s.exp_stall = exp_stall;
        s.exp       = exp;
        steps.push_back(s);
    endtask

    // events carry a writing instruction that must not be taken
    task automatic add_other(input string name, input int kind, input rename_pkg::preg_t preg);
        step_t s;
        s.name      = name;
        s.kind      = kind;
        s.word      = r_type_word(9, 1, 2);
        s.preg      = preg;
        s.exp_stall = (kind == KIND_EXC) || (kind == KIND_MRET);
        s.exp       = '0;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_rename("basic_r", r_type_word(3, 1, 2), 1'b0, make_result(1, 2, 32, 3, 1, 1));
        add_rename("raw_dep", r_type_word(3, 3, 1), 1'b0, make_result(32, 1, 33, 32, 1, 1));
        add_rename("i_type", i_type_word(5, 3), 1'b0, make_result(33, 0, 34, 5, 0, 1));
        add_rename("rd_x0", r_type_word(0, 5, 3), 1'b0, make_result(34, 33, 0, 0, 1, 0));
        add_rename("after_x0", i_type_word(6, 0), 1'b0, make_result(0, 0, 35, 6, 0, 1));
        add_other("exception", KIND_EXC, 0);
        add_rename("trap_r", r_type_word(3, 6, 5), 1'b0, make_result(35, 34, 36, 33, 1, 1));
        add_rename("trap_i", i_type_word(6, 3), 1'b0, make_result(36, 0, 37, 35, 0, 1));
        add_other("mret", KIND_MRET, 0);
        add_rename("after_mret", r_type_word(7, 3, 6), 1'b0, make_result(33, 35, 36, 7, 1, 1));
        for (int k = 0; k < 27; k++) begin
            add_rename($sformatf("drain_%0d", k), i_type_word(10, 0), 1'b0,
                       make_result(0, 0, 37 + k, (k == 0) ? 10 : 36 + k, 0, 1));
        end
        add_rename("empty_stall", i_type_word(11, 0), 1'b1, make_result(0, 0, 0, 0, 0, 0));
        add_other("commit_p5", KIND_COMMIT, 5);
        add_rename("reuse_p5", i_type_word(11, 0), 1'b0, make_result(0, 0, 5, 11, 0, 1));
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic run_step(input step_t s);
        int waited;
        @(negedge clk);
        instr         = s.word;
        instr_valid   = (s.kind != KIND_COMMIT);
        commit_valid  = (s.kind == KIND_COMMIT);
        commit_preg   = s.preg;
        exception_sig = (s.kind == KIND_EXC);
        mret_sig      = (s.kind == KIND_MRET);
        #(CLK_PERIOD / 4);
        check({s.name, " stall"}, s.exp_stall, stall);
        @(negedge clk);
        instr_valid   = 1'b0;
        commit_valid  = 1'b0;
        exception_sig = 1'b0;
        mret_sig      = 1'b0;
        if (s.kind == KIND_MRET) begin
            check({s.name, " restore_done"}, 1'b1, restore_done);
        end
        if (s.kind != KIND_RENAME || s.exp_stall) begin
            check({s.name, " out_valid"}, 1'b0, out_valid);   // nothing was taken
        end else begin
            waited = 0;
            while (!out_valid && waited < MAX_WAIT) begin
                @(negedge clk);
                waited++;
            end
            if (!out_valid) begin
                errors++;
                $display("step %s: out_valid did not rise within %0d cycles", s.name, MAX_WAIT);
            end else begin
                check({s.name, " latency"}, 0, waited);
                check({s.name, " ps1"}, s.exp.ps1, out.ps1);
                check({s.name, " ps2"}, s.exp.ps2, out.ps2);
                check({s.name, " pd"}, s.exp.pd, out.pd);
                check({s.name, " old_pd"}, s.exp.old_pd, out.old_pd);
                check({s.name, " uses_rs2"}, s.exp.uses_rs2, out.uses_rs2);
                check({s.name, " writes_rd"}, s.exp.writes_rd, out.writes_rd);
            end
        end
    endtask

    initial begin
        seed          = 67146;
        errors        = 0;
        checks        = 0;
        reset         = 1'b1;
        instr_valid   = 1'b0;
        instr         = r_type_word(3, 1, 2);
        commit_valid  = 1'b0;
        commit_preg   = '0;
        exception_sig = 1'b0;
        mret_sig      = 1'b1;                         // masked by reset
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("reset restore_done", 1'b0, restore_done);
        mret_sig    = 1'b0;
        instr_valid = 1'b1;                           // writing instruction held in reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("reset out_valid", 1'b0, out_valid);
        reset       = 1'b0;
        instr_valid = 1'b0;
        foreach (steps[n]) begin
            run_step(steps[n]);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
src/rename_pkg.sv
src/rename_map_table.sv
src/free_list.sv
src/rename_stage.sv
src/rename_top.sv
sim/rename_sva.sv
sim/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - files:
      - src/rename_pkg.sv
      - src/rename_map_table.sv
      - src/free_list.sv
      - src/rename_stage.sv
      - src/rename_top.sv
  - target: test
    files:
      - sim/rename_sva.sv
      - sim/rename_tb.sv
